// File: hw/alu_unit.sv
// Single-cycle ALU with registered operands

`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module alu_unit (
    input  logic    clock,
    input  logic    reset,
    input  logic    alu_en,
    fu_op_if.unit   op,
    fu_done_if.unit done_if
);
    import ex_pkg::*;

    xlen_t                opa_q, opb_q, npc_q;
    alu_func_e            func_q;
    reg_idx_t             dest_q;
    rob_tag_t             tag_q;
    logic [`SHAMT_W-1:0]  shamt;

    assign shamt = opb_q[`SHAMT_W-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            done_if.done <= 1'b0;
        end else begin
            done_if.done <= alu_en;
        end
    end

    // Operation capture
    always_ff @(posedge clock) begin
        if (alu_en) begin
            opa_q  <= op.opa;
            opb_q  <= op.opb;
            func_q <= op.alu_func;
            npc_q  <= op.npc;
            dest_q <= op.dest_reg;
            tag_q  <= op.rob_tag;
        end
    end

    always_comb begin
        case (func_q)
            ALU_ADD:  done_if.result = opa_q + opb_q;
            ALU_SUB:  done_if.result = opa_q - opb_q;
            ALU_AND:  done_if.result = opa_q & opb_q;
            ALU_OR:   done_if.result = opa_q | opb_q;
            ALU_XOR:  done_if.result = opa_q ^ opb_q;
            ALU_SLT:  done_if.result = xlen_t'($signed(opa_q) < $signed(opb_q));
            ALU_SLTU: done_if.result = xlen_t'(opa_q < opb_q);
            ALU_SLL:  done_if.result = opa_q << shamt;
            ALU_SRL:  done_if.result = opa_q >> shamt;
            ALU_SRA:  done_if.result = $signed(opa_q) >>> shamt;
            default:  done_if.result = '0;      // Multiply codes never issue here
        endcase
    end

    assign done_if.take_branch = 1'b0;
    assign done_if.npc         = npc_q;
    assign done_if.dest_reg    = dest_q;
    assign done_if.rob_tag     = tag_q;

endmodule

`default_nettype wire

// File: hw/branch_unit.sv
// Branch unit with target adder and condition check

`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic    clock,
    input  logic    reset,
    input  logic    branch_en,
    fu_op_if.unit   op,
    fu_done_if.unit done_if
);
    import ex_pkg::*;

    xlen_t    opa_q, opb_q, rs1_q, rs2_q, npc_q;
    funct3_t  funct3_q;
    logic     cond_q, uncond_q;
    reg_idx_t dest_q;
    rob_tag_t tag_q;
    logic     cond_true;

    always_ff @(posedge clock) begin
        if (reset) begin
            done_if.done <= 1'b0;
        end else begin
            done_if.done <= branch_en;
        end
    end

    always_ff @(posedge clock) begin
        if (branch_en) begin
            opa_q    <= op.opa;
            opb_q    <= op.opb;
            rs1_q    <= op.rs1;
            rs2_q    <= op.rs2;
            funct3_q <= op.funct3;
            cond_q   <= op.cond_branch;
            uncond_q <= op.uncond_branch;
            npc_q    <= op.npc;
            dest_q   <= op.dest_reg;
            tag_q    <= op.rob_tag;
        end
    end

    ////////////////////////////////////////////////////////////
    // Condition from funct3
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3_q)
            3'b000:  cond_true = (rs1_q == rs2_q);                   // BEQ
            3'b001:  cond_true = (rs1_q != rs2_q);                   // BNE
            3'b100:  cond_true = ($signed(rs1_q) <  $signed(rs2_q)); // BLT
            3'b101:  cond_true = ($signed(rs1_q) >= $signed(rs2_q)); // BGE
            3'b110:  cond_true = (rs1_q <  rs2_q);                   // BLTU
            3'b111:  cond_true = (rs1_q >= rs2_q);                   // BGEU
            default: cond_true = 1'b0;
        endcase
    end

    // Jumps always taken
    assign done_if.take_branch = uncond_q | (cond_q & cond_true);
    assign done_if.result      = opa_q + opb_q;
    assign done_if.npc         = npc_q;
    assign done_if.dest_reg    = dest_q;
    assign done_if.rob_tag     = tag_q;

endmodule

`default_nettype wire

// File: hw/completion_arbiter.sv
// Completion arbiter with one waiting slot per unit,
// fixed priority ALU > multiplier > branch

`timescale 1ns/1ps
`default_nettype none

module completion_arbiter (
    input  logic             clock,
    input  logic             reset,
    fu_done_if.arb           alu_done,
    fu_done_if.arb           mult_done,
    fu_done_if.arb           branch_done,
    output logic             ex_valid,
    output ex_pkg::xlen_t    ex_result,
    output ex_pkg::xlen_t    ex_npc,
    output logic             ex_take_branch,
    output ex_pkg::reg_idx_t ex_dest_reg,
    output ex_pkg::rob_tag_t ex_rob_tag,
    output logic             free_alu,
    output logic             free_mult,
    output logic             free_branch
);
    import ex_pkg::*;

    localparam int NUM_SLOTS = 3;   // Index is also the priority rank

    typedef struct packed {
        xlen_t    result;
        logic     take_branch;
        xlen_t    npc;
        reg_idx_t dest_reg;
        rob_tag_t rob_tag;
    } slot_t;

    logic [NUM_SLOTS-1:0]         in_done, full, grant;
    logic [$clog2(NUM_SLOTS)-1:0] sel;
    slot_t                        in_slot [NUM_SLOTS];
    slot_t                        slot    [NUM_SLOTS];

    assign in_done    = {branch_done.done, mult_done.done, alu_done.done};
    assign in_slot[0] = {alu_done.result, alu_done.take_branch, alu_done.npc,
                         alu_done.dest_reg, alu_done.rob_tag};
    assign in_slot[1] = {mult_done.result, mult_done.take_branch, mult_done.npc,
                         mult_done.dest_reg, mult_done.rob_tag};
    assign in_slot[2] = {branch_done.result, branch_done.take_branch, branch_done.npc,
                         branch_done.dest_reg, branch_done.rob_tag};

    // Lowest full index wins
    always_comb begin
        sel   = '0;
        grant = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (full[i]) sel = i[$clog2(NUM_SLOTS)-1:0];
        end
        if (full[sel]) grant[sel] = 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            full                              <= '0;
            ex_valid                          <= 1'b0;
            {free_branch, free_mult, free_alu} <= '0;
        end else begin
            full                              <= (full & ~grant) | in_done;
            ex_valid                          <= |full;
            {free_branch, free_mult, free_alu} <= grant;
        end
    end

    // Slot payloads and the result port
    always_ff @(posedge clock) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (in_done[i]) slot[i] <= in_slot[i];
        end
        if (|full)
            {ex_result, ex_take_branch, ex_npc, ex_dest_reg, ex_rob_tag} <= slot[sel];
    end

endmodule

`default_nettype wire

// File: hw/ex_consts.svh
// Execute stage widths, multiplier step count
// and poison words for bad operand selects

`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

`define XLEN        32
`define REG_IDX_W   5
`define ROB_TAG_W   4
`define SHAMT_W     5

// 64-bit multiplier operand retired 8 bits per step
`define MULT_STEPS  8

`define OPA_POISON  32'hdeadface
`define OPB_POISON  32'hfacefeed

`endif

// File: hw/ex_ifs.sv
// fu_op_if carries the selected operation to the units
// fu_done_if carries one finished result to the arbiter

`timescale 1ns/1ps
`default_nettype none

interface fu_op_if;
    import ex_pkg::*;

    xlen_t     opa;
    xlen_t     opb;
    alu_func_e alu_func;
    xlen_t     rs1;
    xlen_t     rs2;
    funct3_t   funct3;
    logic      cond_branch;
    logic      uncond_branch;
    xlen_t     npc;
    reg_idx_t  dest_reg;
    rob_tag_t  rob_tag;

    modport src  (output opa, opb, alu_func, rs1, rs2, funct3, cond_branch,
                  uncond_branch, npc, dest_reg, rob_tag);
    modport unit (input  opa, opb, alu_func, rs1, rs2, funct3, cond_branch,
                  uncond_branch, npc, dest_reg, rob_tag);
endinterface

interface fu_done_if;
    import ex_pkg::*;

    logic     done;         // One cycle pulse
    xlen_t    result;
    logic     take_branch;
    xlen_t    npc;
    reg_idx_t dest_reg;
    rob_tag_t rob_tag;

    modport unit (output done, result, take_branch, npc, dest_reg, rob_tag);
    modport arb  (input  done, result, take_branch, npc, dest_reg, rob_tag);
endinterface

`default_nettype wire

// File: hw/ex_pkg.sv
// Execute stage package
// Word and field typedefs, operation and select enums

`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0]      xlen_t;
    typedef logic [2*`XLEN-1:0]    dword_t;
    typedef logic [31:0]           inst_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [2:0]            funct3_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1, OPA_IS_NPC, OPA_IS_PC, OPA_IS_ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2, OPB_IS_I_IMM, OPB_IS_S_IMM,
        OPB_IS_B_IMM, OPB_IS_U_IMM, OPB_IS_J_IMM
    } opb_sel_e;

    typedef enum logic [1:0] {
        MULT_IDLE, MULT_RUN, MULT_FINISH
    } mult_state_e;

endpackage

`default_nettype wire

// File: hw/mult_unit.sv
// Iterative shift-add multiplier for MUL, MULH, MULHSU and MULHU

`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module mult_unit (
    input  logic    clock,
    input  logic    reset,
    input  logic    mult_en,
    fu_op_if.unit   op,
    fu_done_if.unit done_if
);
    import ex_pkg::*;

    localparam int STEP_W = 2 * `XLEN / `MULT_STEPS;   // Multiplier bits per step
    localparam int CNT_W  = $clog2(`MULT_STEPS);

    mult_state_e      state;
    logic [CNT_W-1:0] step_cnt;
    dword_t           mcand, mplier, product;
    alu_func_e        func_q;
    xlen_t            npc_q;
    reg_idx_t         dest_q;
    rob_tag_t         tag_q;
    logic             signed_a, signed_b;
    logic             load;

    assign signed_a = op.alu_func inside {ALU_MUL, ALU_MULH, ALU_MULHSU};
    assign signed_b = op.alu_func inside {ALU_MUL, ALU_MULH};
    assign load     = mult_en && (state == MULT_IDLE);

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= MULT_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                MULT_IDLE: if (mult_en) begin
                    state    <= MULT_RUN;
                    step_cnt <= '0;
                end
                MULT_RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == CNT_W'(`MULT_STEPS - 1))
                        state <= MULT_FINISH;
                end
                default: state <= MULT_IDLE;    // FINISH lasts one cycle
            endcase
        end
    end

    // Both operands widened to 64 bits, so the low 64 product bits are exact
    always_ff @(posedge clock) begin
        if (load) begin
            mcand   <= {{`XLEN{signed_a & op.opa[`XLEN-1]}}, op.opa};
            mplier  <= {{`XLEN{signed_b & op.opb[`XLEN-1]}}, op.opb};
            product <= '0;
            func_q  <= op.alu_func;
            npc_q   <= op.npc;
            dest_q  <= op.dest_reg;
            tag_q   <= op.rob_tag;
        end else if (state == MULT_RUN) begin
            product <= product + mcand * dword_t'(mplier[STEP_W-1:0]);
            mcand   <= mcand << STEP_W;
            mplier  <= mplier >> STEP_W;
        end
    end

    assign done_if.done        = (state == MULT_FINISH);
    assign done_if.result      = (func_q == ALU_MUL) ? product[`XLEN-1:0]
                                                     : product[2*`XLEN-1:`XLEN];
    assign done_if.take_branch = 1'b0;
    assign done_if.npc         = npc_q;
    assign done_if.dest_reg    = dest_q;
    assign done_if.rob_tag     = tag_q;

endmodule

`default_nettype wire

// File: hw/operand_select.sv
// Operand A/B muxes and RV32 immediate decode

`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module operand_select (
    input  ex_pkg::xlen_t     pc,
    input  ex_pkg::xlen_t     npc,
    input  ex_pkg::xlen_t     rs1_value,
    input  ex_pkg::xlen_t     rs2_value,
    input  ex_pkg::inst_t     inst,
    input  ex_pkg::opa_sel_e  opa_select,
    input  ex_pkg::opb_sel_e  opb_select,
    input  ex_pkg::alu_func_e alu_func,
    input  logic              cond_branch,
    input  logic              uncond_branch,
    input  ex_pkg::reg_idx_t  dest_reg,
    input  ex_pkg::rob_tag_t  rob_tag,
    fu_op_if.src              op
);
    import ex_pkg::*;

    xlen_t i_imm, s_imm, b_imm, u_imm, j_imm;

    // Sign-extended immediates, one per format
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (opa_select)
            OPA_IS_RS1:  op.opa = rs1_value;
            OPA_IS_NPC:  op.opa = npc;
            OPA_IS_PC:   op.opa = pc;
            OPA_IS_ZERO: op.opa = '0;
            default:     op.opa = `OPA_POISON;
        endcase
    end

    always_comb begin
        case (opb_select)
            OPB_IS_RS2:   op.opb = rs2_value;
            OPB_IS_I_IMM: op.opb = i_imm;
            OPB_IS_S_IMM: op.opb = s_imm;
            OPB_IS_B_IMM: op.opb = b_imm;
            OPB_IS_U_IMM: op.opb = u_imm;
            OPB_IS_J_IMM: op.opb = j_imm;
            default:      op.opb = `OPB_POISON;   // Codes 6 and 7
        endcase
    end

    assign op.alu_func      = alu_func;
    assign op.rs1           = rs1_value;
    assign op.rs2           = rs2_value;
    assign op.funct3        = inst[14:12];
    assign op.cond_branch   = cond_branch;
    assign op.uncond_branch = uncond_branch;
    assign op.npc           = npc;
    assign op.dest_reg      = dest_reg;
    assign op.rob_tag       = rob_tag;

endmodule

`default_nettype wire

// File: hw/stage_ex.sv
// Execute stage top level
// Operand select, ALU, branch unit, multiplier and completion arbiter

`timescale 1ns/1ps
`default_nettype none

module stage_ex (
    input  logic              clock,
    input  logic              reset,
    input  logic              alu_en,
    input  logic              mult_en,
    input  logic              branch_en,
    input  ex_pkg::xlen_t     pc,
    input  ex_pkg::xlen_t     npc,
    input  ex_pkg::xlen_t     rs1_value,
    input  ex_pkg::xlen_t     rs2_value,
    input  ex_pkg::inst_t     inst,
    input  ex_pkg::opa_sel_e  opa_select,
    input  ex_pkg::opb_sel_e  opb_select,
    input  ex_pkg::alu_func_e alu_func,
    input  logic              cond_branch,
    input  logic              uncond_branch,
    input  ex_pkg::reg_idx_t  dest_reg,
    input  ex_pkg::rob_tag_t  rob_tag,
    output logic              ex_valid,
    output ex_pkg::xlen_t     ex_result,
    output ex_pkg::xlen_t     ex_npc,
    output logic              ex_take_branch,
    output ex_pkg::reg_idx_t  ex_dest_reg,
    output ex_pkg::rob_tag_t  ex_rob_tag,
    output logic              free_alu,
    output logic              free_mult,
    output logic              free_branch
);

    fu_op_if   op_bus ();
    fu_done_if alu_done_bus ();
    fu_done_if mult_done_bus ();
    fu_done_if branch_done_bus ();

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    operand_select u_operand_select (
        .pc            (pc),
        .npc           (npc),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .inst          (inst),
        .opa_select    (opa_select),
        .opb_select    (opb_select),
        .alu_func      (alu_func),
        .cond_branch   (cond_branch),
        .uncond_branch (uncond_branch),
        .dest_reg      (dest_reg),
        .rob_tag       (rob_tag),
        .op            (op_bus.src)
    );

    ////////////////////////////////////////////////////////////
    // Functional units
    ////////////////////////////////////////////////////////////

    alu_unit u_alu (
        .clock   (clock),
        .reset   (reset),
        .alu_en  (alu_en),
        .op      (op_bus.unit),
        .done_if (alu_done_bus.unit)
    );

    branch_unit u_branch (
        .clock     (clock),
        .reset     (reset),
        .branch_en (branch_en),
        .op        (op_bus.unit),
        .done_if   (branch_done_bus.unit)
    );

    mult_unit u_mult (
        .clock   (clock),
        .reset   (reset),
        .mult_en (mult_en),
        .op      (op_bus.unit),
        .done_if (mult_done_bus.unit)
    );

    completion_arbiter u_arbiter (
        .clock          (clock),
        .reset          (reset),
        .alu_done       (alu_done_bus.arb),
        .mult_done      (mult_done_bus.arb),
        .branch_done    (branch_done_bus.arb),
        .ex_valid       (ex_valid),
        .ex_result      (ex_result),
        .ex_npc         (ex_npc),
        .ex_take_branch (ex_take_branch),
        .ex_dest_reg    (ex_dest_reg),
        .ex_rob_tag     (ex_rob_tag),
        .free_alu       (free_alu),
        .free_mult      (free_mult),
        .free_branch    (free_branch)
    );

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
+incdir+testbench
hw/ex_pkg.sv
hw/ex_ifs.sv
hw/operand_select.sv
hw/alu_unit.sv
hw/branch_unit.sv
hw/mult_unit.sv
hw/completion_arbiter.sv
hw/stage_ex.sv
testbench/tb_stage_ex.sv

// File: testbench/tb_ex_tasks.svh
// Issue, wait and compare tasks for the execute stage testbench
// Included inside the testbench module body

`ifndef TB_EX_TASKS_SVH
`define TB_EX_TASKS_SVH

task automatic compare_word(input string name, input xlen_t exp, input xlen_t got);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
endtask

task automatic compare_tag(input string name, input rob_tag_t exp, input rob_tag_t got);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
    end
endtask

task automatic compare_reg(input string name, input reg_idx_t exp, input reg_idx_t got);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
    end
endtask

task automatic compare_bit(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("** Error at %0t: %s expected %b got %b", $time, name, exp, got);
    end
endtask

// Bit order is {branch, mult, alu}
task automatic check_frees(input logic [2:0] exp, input logic [2:0] got);
    compare_bit("free_alu", exp[0], got[0]);
    compare_bit("free_mult", exp[1], got[1]);
    compare_bit("free_branch", exp[2], got[2]);
endtask

// Drives one operation for a single cycle and returns at the edge that samples it
task automatic issue_op(input logic [2:0] en, input alu_func_e f, input opa_sel_e sa,
                        input opb_sel_e sb, input xlen_t a, input xlen_t b, input inst_t i,
                        input logic cb, input logic ub, output rob_tag_t tag);
    tag = next_tag;
    next_tag = next_tag + 1'b1;
    @(posedge clock);
    {branch_en, mult_en, alu_en} <= en;
    alu_func      <= f;
    opa_select    <= sa;
    opb_select    <= sb;
    rs1_value     <= a;
    rs2_value     <= b;
    inst          <= i;
    cond_branch   <= cb;
    uncond_branch <= ub;
    pc            <= cur_pc;
    npc           <= cur_pc + 32'd4;
    rob_tag       <= tag;
    dest_reg      <= {1'b1, tag};
    @(posedge clock);
    {branch_en, mult_en, alu_en} <= 3'b000;
endtask

// Latency counts edges after the issue edge
task automatic wait_result(input rob_tag_t tag, input logic any_tag, output int latency);
    int n;
    n = 0;
    latency = -1;
    while (latency < 0 && n < WAIT_LIMIT) begin
        @(negedge clock);
        if (ex_valid && (any_tag || ex_rob_tag == tag)) latency = n;
        n++;
    end
    if (latency < 0) begin
        errors++;
        $display("Timeout: no result for tag %0d within %0d cycles", tag, WAIT_LIMIT);
    end
endtask

task automatic expect_result(input rob_tag_t tag, input xlen_t exp, input logic exp_take,
                             input logic [2:0] exp_free, input int exp_latency);
    int latency;
    wait_result(tag, exp_latency >= 0, latency);
    if (latency >= 0) begin
        if (exp_latency >= 0 && latency != exp_latency) begin
            errors++;
            $display("** Error at %0t: ex_valid latency expected %0d got %0d",
                     $time, exp_latency, latency);
        end
        compare_word("ex_result", exp, ex_result);
        compare_word("ex_npc", cur_pc + 32'd4, ex_npc);
        compare_bit("ex_take_branch", exp_take, ex_take_branch);
        compare_tag("ex_rob_tag", tag, ex_rob_tag);
        compare_reg("ex_dest_reg", {1'b1, tag}, ex_dest_reg);
        check_frees(exp_free, {free_branch, free_mult, free_alu});
    end
endtask

task automatic report_test(input string name, input int start_errors);
    tests++;
    $display("Test %-18s done, %0d errors", name, errors - start_errors);
endtask

`endif

// File: testbench/tb_stage_ex.sv
// Testbench for the execute stage
// Clock, reset, DUT, reference functions and directed tests

`timescale 1ns/1ps
`default_nettype none

module tb_stage_ex;
    import ex_pkg::*;

    localparam int WAIT_LIMIT = 40;     // Cycles before a wait gives up

    logic      clock, reset;
    logic      alu_en, mult_en, branch_en;
    xlen_t     pc, npc, rs1_value, rs2_value;
    inst_t     inst;
    opa_sel_e  opa_select;
    opb_sel_e  opb_select;
    alu_func_e alu_func;
    logic      cond_branch, uncond_branch;
    reg_idx_t  dest_reg;
    rob_tag_t  rob_tag;
    logic      ex_valid, ex_take_branch;
    xlen_t     ex_result, ex_npc;
    reg_idx_t  ex_dest_reg;
    rob_tag_t  ex_rob_tag;
    logic      free_alu, free_mult, free_branch;

    int       errors = 0;
    int       checks = 0;
    int       tests = 0;
    rob_tag_t next_tag = '0;
    xlen_t    cur_pc;

    stage_ex dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    `include "tb_ex_tasks.svh"

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic xlen_t alu_ref(input alu_func_e f, input xlen_t a, input xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default:  return '0;
        endcase
    endfunction

    function automatic logic taken_ref(input funct3_t f3, input logic cond, input logic uncond,
                                       input xlen_t a, input xlen_t b);
        logic lt_s, lt_u;
        lt_u = a < b;
        lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);   // Flip sign bit for signed order
        if (uncond) return 1'b1;
        if (!cond) return 1'b0;
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return lt_s;
            3'b101:  return !lt_s;
            3'b110:  return lt_u;
            3'b111:  return !lt_u;
            default: return 1'b0;
        endcase
    endfunction

    function automatic xlen_t mult_ref(input alu_func_e f, input xlen_t a, input xlen_t b);
        longint sa, sb, ua, ub;
        dword_t p;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        ua = longint'(a);
        ub = longint'(b);
        case (f)
            ALU_MUL, ALU_MULH: p = sa * sb;
            ALU_MULHSU:        p = sa * ub;
            default:           p = ua * ub;
        endcase
        return (f == ALU_MUL) ? p[31:0] : p[63:32];
    endfunction

    // RV32 encoders that invert the immediate decode
    function automatic inst_t i_word(input xlen_t imm);
        return {imm[11:0], 5'd3, 3'b000, 5'd1, 7'b0010011};
    endfunction

    function automatic inst_t s_word(input xlen_t imm);
        return {imm[11:5], 5'd2, 5'd3, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic inst_t b_word(input xlen_t imm, input funct3_t f3);
        return {imm[12], imm[10:5], 5'd2, 5'd3, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic inst_t u_word(input xlen_t imm);
        return {imm[31:12], 5'd1, 7'b0110111};
    endfunction

    function automatic inst_t j_word(input xlen_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic idle_after_reset();
        int start;
        start = errors;
        for (int n = 0; n < 5; n++) begin
            @(negedge clock);
            compare_bit("ex_valid", 1'b0, ex_valid);
            check_frees(3'b000, {free_branch, free_mult, free_alu});
        end
        report_test("idle_after_reset", start);
    endtask

    task automatic alu_ops();
        xlen_t     a, b;
        alu_func_e f;
        rob_tag_t  tag;
        int        start;
        start = errors;
        for (int k = 0; k < 20; k++) begin
            f = alu_func_e'(k % 10);
            a = $urandom;
            b = $urandom;
            issue_op(3'b001, f, OPA_IS_RS1, OPB_IS_RS2, a, b, '0, 1'b0, 1'b0, tag);
            expect_result(tag, alu_ref(f, a, b), 1'b0, 3'b001, 2);
        end
        report_test("alu_ops", start);
    endtask

    task automatic add_with_imm(input opa_sel_e sa, input xlen_t opa_exp, input xlen_t a,
                                input opb_sel_e sb, input inst_t i, input xlen_t imm);
        rob_tag_t tag;
        issue_op(3'b001, ALU_ADD, sa, sb, a, ~a, i, 1'b0, 1'b0, tag);
        expect_result(tag, opa_exp + imm, 1'b0, 3'b001, 2);
    endtask

    task automatic operand_sources();
        xlen_t a;
        int    start;
        start = errors;
        a = $urandom;
        add_with_imm(OPA_IS_NPC, cur_pc + 32'd4, a, OPB_IS_I_IMM,
                     i_word(32'hffff_ff85), 32'hffff_ff85);
        add_with_imm(OPA_IS_PC, cur_pc, a, OPB_IS_S_IMM,
                     s_word(32'hffff_f804), 32'hffff_f804);
        add_with_imm(OPA_IS_ZERO, 32'd0, a, OPB_IS_B_IMM,
                     b_word(32'hffff_f002, 3'b000), 32'hffff_f002);
        add_with_imm(OPA_IS_RS1, a, a, OPB_IS_U_IMM,
                     u_word(32'habcd_e000), 32'habcd_e000);
        add_with_imm(OPA_IS_PC, cur_pc, a, OPB_IS_J_IMM,
                     j_word(32'hfff0_1a2e), 32'hfff0_1a2e);
        report_test("operand_sources", start);
    endtask

    task automatic branch_conditions();
        xlen_t    a, b;
        inst_t    i;
        rob_tag_t tag;
        int       start;
        start = errors;
        // All eight funct3 codes, so 010 and 011 cover the undefined ones
        for (int k = 0; k < 8; k++) begin
            for (int p = 0; p < 5; p++) begin
                case (p)
                    0:       begin a = 32'h0000_1234; b = 32'h0000_1234; end
                    1:       begin a = 32'd3;         b = 32'd100;       end
                    2:       begin a = 32'd100;       b = 32'd3;         end
                    3:       begin a = 32'hffff_fff0; b = 32'd5;         end
                    default: begin a = 32'd5;         b = 32'hffff_fff0; end
                endcase
                i = b_word(32'hffff_ff40, funct3_t'(k));
                issue_op(3'b100, ALU_ADD, OPA_IS_PC, OPB_IS_B_IMM, a, b, i, 1'b1, 1'b0, tag);
                expect_result(tag, cur_pc + 32'hffff_ff40,
                              taken_ref(funct3_t'(k), 1'b1, 1'b0, a, b), 3'b100, 2);
            end
        end
        a = $urandom;
        issue_op(3'b100, ALU_ADD, OPA_IS_PC, OPB_IS_J_IMM, a, a, j_word(32'h0000_0ff4),
                 1'b0, 1'b1, tag);   // JAL
        expect_result(tag, cur_pc + 32'h0000_0ff4, 1'b1, 3'b100, 2);
        issue_op(3'b100, ALU_ADD, OPA_IS_RS1, OPB_IS_I_IMM, a, a, i_word(32'hffff_ff85),
                 1'b0, 1'b1, tag);   // JALR
        expect_result(tag, a + 32'hffff_ff85, 1'b1, 3'b100, 2);
        report_test("branch_conditions", start);
    endtask

    task automatic multiply_ops();
        xlen_t     a, b;
        alu_func_e f;
        rob_tag_t  tag;
        int        start;
        start = errors;
        for (int k = 0; k < 4; k++) begin
            f = alu_func_e'(ALU_MUL + k);
            for (int p = 0; p < 6; p++) begin
                case (p)
                    0:       begin a = 32'h8000_0000; b = 32'h8000_0000; end
                    1:       begin a = 32'hffff_ffff; b = 32'h8000_0000; end
                    2:       begin a = 32'hffff_ffff; b = 32'hffff_ffff; end
                    3:       begin a = 32'h8000_0000; b = 32'h7fff_ffff; end
                    default: begin a = $urandom;      b = $urandom;      end
                endcase
                issue_op(3'b010, f, OPA_IS_RS1, OPB_IS_RS2, a, b, '0, 1'b0, 1'b0, tag);
                expect_result(tag, mult_ref(f, a, b), 1'b0, 3'b010, -1);
            end
        end
        report_test("multiply_ops", start);
    endtask

    task automatic arbitration_order();
        xlen_t      ma, mb, a, b;
        rob_tag_t   mtag, tag;
        xlen_t      got_res [3];
        rob_tag_t   got_tag [3];
        logic       got_take [3];
        logic [2:0] got_free [3];
        int         got_cyc [3];
        int         seen, n, start;
        start = errors;
        ma = $urandom;
        mb = $urandom;
        a = $urandom;
        b = $urandom;
        issue_op(3'b010, ALU_MULHSU, OPA_IS_RS1, OPB_IS_RS2, ma, mb, '0, 1'b0, 1'b0, mtag);
        // Multiplier done lands on the same edge as the ALU and branch done
        repeat (6) @(posedge clock);
        // ALU and branch capture the same bus, so they share one tag
        issue_op(3'b101, ALU_XOR, OPA_IS_RS1, OPB_IS_RS2, a, b, '0, 1'b1, 1'b0, tag);
        seen = 0;
        n = 0;
        while (seen < 3 && n < WAIT_LIMIT) begin
            @(negedge clock);
            if (ex_valid) begin
                got_res[seen]  = ex_result;
                got_tag[seen]  = ex_rob_tag;
                got_take[seen] = ex_take_branch;
                got_free[seen] = {free_branch, free_mult, free_alu};
                got_cyc[seen]  = n;
                seen++;
            end
            n++;
        end
        if (seen < 3) begin
            errors++;
            $display("Timeout: only %0d of 3 results came out", seen);
        end else begin
            compare_tag("ex_rob_tag", tag, got_tag[0]);
            compare_word("ex_result", alu_ref(ALU_XOR, a, b), got_res[0]);
            check_frees(3'b001, got_free[0]);
            compare_tag("ex_rob_tag", mtag, got_tag[1]);
            compare_word("ex_result", mult_ref(ALU_MULHSU, ma, mb), got_res[1]);
            check_frees(3'b010, got_free[1]);
            compare_tag("ex_rob_tag", tag, got_tag[2]);
            compare_word("ex_result", a + b, got_res[2]);
            compare_bit("ex_take_branch", taken_ref(3'b000, 1'b1, 1'b0, a, b), got_take[2]);
            check_frees(3'b100, got_free[2]);
            if (got_cyc[1] != got_cyc[0] + 1 || got_cyc[2] != got_cyc[1] + 1) begin
                errors++;
                $display("The three results did not come out on consecutive cycles");
            end
        end
        report_test("arbitration_order", start);
    endtask

    task automatic finish_run();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'h79e5));
        reset         = 1'b1;
        alu_en        = 1'b0;
        mult_en       = 1'b0;
        branch_en     = 1'b0;
        pc            = '0;
        npc           = '0;
        rs1_value     = '0;
        rs2_value     = '0;
        inst          = '0;
        opa_select    = OPA_IS_RS1;
        opb_select    = OPB_IS_RS2;
        alu_func      = ALU_ADD;
        cond_branch   = 1'b0;
        uncond_branch = 1'b0;
        dest_reg      = '0;
        rob_tag       = '0;
        cur_pc        = $urandom & 32'hffff_fffc;   // Word aligned
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        idle_after_reset();
        alu_ops();
        operand_sources();
        branch_conditions();
        multiply_ops();
        arbitration_order();
        finish_run();
    end

endmodule

`default_nettype wire
